// ==== include/tl_ref_model.svh ====
`ifndef TL_REF_MODEL_SVH
`define TL_REF_MODEL_SVH

// Expected store-buffer queue, oldest entry first
tl_types_pkg::sb_entry_t sb_q[$];

// Expected cache valid bits and tags
logic [NUM_LINES-1:0]    line_valid;
mem_cfg_pkg::tag_t       line_tag [NUM_LINES];

function automatic void clear_model();
    sb_q.delete();
    line_valid = '0;
endfunction

function automatic mem_cfg_pkg::tag_t tag_of(input mem_cfg_pkg::addr_t addr);
    return mem_cfg_pkg::tag_t'(addr >> mem_cfg_pkg::LINE_OFFSET_W);
endfunction

function automatic logic cache_hit(input mem_cfg_pkg::addr_t addr);
    int idx;
    idx = int'(tag_of(addr) % NUM_LINES);
    return line_valid[idx] && (line_tag[idx] == tag_of(addr));
endfunction

// Direct mapped, a refill replaces whatever the set held
function automatic void refill_line(input mem_cfg_pkg::addr_t addr);
    int idx;
    idx             = int'(tag_of(addr) % NUM_LINES);
    line_valid[idx] = 1'b1;
    line_tag[idx]   = tag_of(addr);
endfunction

// Position in the queue of the entry with this addr and type, or -1
function automatic int find_entry(input mem_cfg_pkg::addr_t addr,
                                  input tl_types_pkg::memop_type_e mtype);
    foreach (sb_q[i]) begin
        if (sb_q[i].addr == addr && sb_q[i].memop_type == mtype) begin
            return i;
        end
    end
    return -1;
endfunction

// A matching entry takes the new data, otherwise the store joins the tail
function automatic void write_store(input tl_types_pkg::sb_entry_t entry);
    int idx;
    idx = find_entry(entry.addr, entry.memop_type);
    if (idx >= 0) begin
        sb_q[idx].data = entry.data;
    end else begin
        sb_q.push_back(entry);
    end
endfunction

`endif

// ==== logic/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    localparam int ADDR_W        = 32;
    localparam int WORD_W        = 32;
    localparam int REG_ADDR_W    = 5;
    // 16-byte lines
    localparam int LINE_OFFSET_W = 4;
    localparam int TAG_W         = ADDR_W - LINE_OFFSET_W;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // Whole line address, independent of the line count
    typedef logic [TAG_W-1:0]      tag_t;

endpackage

// ==== logic/tl_types_pkg.sv ====
package tl_types_pkg;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_type_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        MISS_IN_FLIGHT,
        HAZARD_DC_MISS,
        HAZARD_SB_FULL
    } tl_state_e;

    // Held steady by execute while the stage stalls
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic                   sign_ext;
        memop_type_e            memop_type;
        mem_cfg_pkg::addr_t     addr;
        mem_cfg_pkg::word_t     data;
        logic                   rf_we;
        mem_cfg_pkg::reg_addr_t rf_waddr;
    } ex_req_t;

    // rdy pulses for one cycle, addr names the refilled line
    typedef struct packed {
        logic               rdy;
        mem_cfg_pkg::addr_t addr;
    } refill_t;

    typedef struct packed {
        mem_cfg_pkg::addr_t addr;
        mem_cfg_pkg::word_t data;
        memop_type_e        memop_type;
    } sb_entry_t;

    // Stage output toward memory, wr means a store-buffer flush write
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic                   sign_ext;
        memop_type_e            memop_type;
        mem_cfg_pkg::addr_t     addr;
        logic                   rf_we;
        mem_cfg_pkg::reg_addr_t rf_waddr;
        logic                   sb_hit;
        mem_cfg_pkg::word_t     load_data;
        sb_entry_t              flush_entry;
        logic                   flush;
    } tl_out_t;

endpackage

// ==== logic/dcache_tag_array.sv ====
`timescale 1ns/10ps

module dcache_tag_array #(
    parameter int NUM_LINES = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  mem_cfg_pkg::addr_t    lookup_addr_i,
    input  tl_types_pkg::refill_t refill_i,
    output logic                  hit_o
);

    localparam int IDX_W = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    mem_cfg_pkg::tag_t    tags_q [NUM_LINES];
    logic [NUM_LINES-1:0] valid_q;
    mem_cfg_pkg::tag_t    lookup_tag;
    mem_cfg_pkg::tag_t    refill_tag;
    idx_t                 lookup_idx;
    idx_t                 refill_idx;

    function automatic mem_cfg_pkg::tag_t line_of(input mem_cfg_pkg::addr_t addr);
        return addr[mem_cfg_pkg::ADDR_W-1:mem_cfg_pkg::LINE_OFFSET_W];
    endfunction

    // Direct mapped, line address modulo the line count
    function automatic idx_t index_of(input mem_cfg_pkg::tag_t line);
        return idx_t'(line % NUM_LINES);
    endfunction

    assign lookup_tag = line_of(lookup_addr_i);
    assign lookup_idx = index_of(lookup_tag);
    assign refill_tag = line_of(refill_i.addr);
    assign refill_idx = index_of(refill_tag);

    assign hit_o = valid_q[lookup_idx] && (tags_q[lookup_idx] == lookup_tag);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (refill_i.rdy) begin
            valid_q[refill_idx] <= 1'b1;
        end
    end

    // Tags only matter once their valid bit is set
    always_ff @(posedge clk_i) begin
        if (refill_i.rdy) begin
            tags_q[refill_idx] <= refill_tag;
        end
    end

    // Uninitialised tags must stay masked by the cleared valid bits
    a_hit_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(hit_o));

endmodule

// ==== logic/store_buffer.sv ====
`timescale 1ns/10ps

module store_buffer #(
    parameter int SB_DEPTH = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      push_i,
    input  tl_types_pkg::sb_entry_t   push_entry_i,
    input  mem_cfg_pkg::addr_t        load_addr_i,
    input  tl_types_pkg::memop_type_e load_type_i,
    input  logic                      flush_i,
    output logic                      fwd_hit_o,
    output mem_cfg_pkg::word_t        fwd_data_o,
    output logic                      full_conflict_o,
    output logic                      head_valid_o,
    output tl_types_pkg::sb_entry_t   head_o
);

    localparam int PTR_W = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    tl_types_pkg::sb_entry_t entries_q [SB_DEPTH];
    logic [SB_DEPTH-1:0]     valid_q;
    ptr_t                    head_q;
    ptr_t                    tail_q;
    logic                    store_match;
    logic                    coal_hit;
    ptr_t                    coal_idx;

    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(SB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Coalescing keeps at most one entry per addr and type
    always_comb begin
        fwd_hit_o   = 1'b0;
        fwd_data_o  = '0;
        store_match = 1'b0;
        coal_hit    = 1'b0;
        coal_idx    = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (valid_q[i] && entries_q[i].addr == load_addr_i
                    && entries_q[i].memop_type == load_type_i) begin
                fwd_hit_o  = 1'b1;
                fwd_data_o = entries_q[i].data;
            end
            if (valid_q[i] && entries_q[i].addr == push_entry_i.addr
                    && entries_q[i].memop_type == push_entry_i.memop_type) begin
                store_match = 1'b1;
                // A head leaving this cycle cannot absorb the store
                if (!(flush_i && ptr_t'(i) == head_q)) begin
                    coal_hit = 1'b1;
                    coal_idx = ptr_t'(i);
                end
            end
        end
    end

    assign full_conflict_o = (&valid_q) && !store_match;
    assign head_valid_o    = valid_q[head_q];
    assign head_o          = entries_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (flush_i) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= next_ptr(head_q);
            end
            // When full, the tail slot is the head freed above
            if (push_i && !coal_hit) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= next_ptr(tail_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            if (coal_hit) begin
                entries_q[coal_idx].data <= push_entry_i.data;
            end else begin
                entries_q[tail_q] <= push_entry_i;
            end
        end
    end

    // The controller must stall a store that has no slot
    a_no_push_on_conflict: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_conflict_o);

    a_no_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> head_valid_o);

endmodule

// ==== logic/tl_stage_ctrl.sv ====
`timescale 1ns/10ps

module tl_stage_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  tl_types_pkg::ex_req_t   ex_req_i,
    input  logic                    store_permission_i,
    input  logic                    refill_rdy_i,
    input  logic                    cache_hit_i,
    input  logic                    sb_fwd_hit_i,
    input  mem_cfg_pkg::word_t      sb_fwd_data_i,
    input  logic                    sb_full_conflict_i,
    input  logic                    sb_head_valid_i,
    input  tl_types_pkg::sb_entry_t sb_head_i,
    output mem_cfg_pkg::addr_t      lookup_addr_o,
    output logic                    sb_push_o,
    output tl_types_pkg::sb_entry_t sb_entry_o,
    output logic                    sb_flush_o,
    output logic                    mmu_miss_o,
    output mem_cfg_pkg::addr_t      mmu_addr_o,
    output logic                    hazard_o,
    output tl_types_pkg::tl_out_t   tl_out_o
);

    tl_types_pkg::tl_state_e state_q;
    tl_types_pkg::tl_state_e state_d;
    mem_cfg_pkg::tag_t       inflight_tag_q;
    mem_cfg_pkg::tag_t       req_tag;
    logic                    same_tag;
    logic                    latch_tag;
    logic                    miss_pending_q;

    assign req_tag  = ex_req_i.addr[mem_cfg_pkg::ADDR_W-1:mem_cfg_pkg::LINE_OFFSET_W];
    assign same_tag = (req_tag == inflight_tag_q);

    // Tag lookup and miss address both follow the held request
    assign lookup_addr_o = ex_req_i.addr;
    assign mmu_addr_o    = ex_req_i.addr;

    assign sb_entry_o.addr       = ex_req_i.addr;
    assign sb_entry_o.data       = ex_req_i.data;
    assign sb_entry_o.memop_type = ex_req_i.memop_type;

    always_comb begin
        state_d    = state_q;
        hazard_o   = 1'b0;
        sb_push_o  = 1'b0;
        sb_flush_o = 1'b0;
        mmu_miss_o = 1'b0;
        latch_tag  = 1'b0;
        unique case (state_q)
            tl_types_pkg::TL_IDLE: begin
                if (ex_req_i.rd) begin
                    if (!cache_hit_i && !sb_fwd_hit_i) begin
                        mmu_miss_o = 1'b1;
                        hazard_o   = 1'b1;
                        state_d    = tl_types_pkg::HAZARD_DC_MISS;
                    end
                end else if (ex_req_i.wr) begin
                    if (sb_full_conflict_i) begin
                        hazard_o = 1'b1;
                        state_d  = tl_types_pkg::HAZARD_SB_FULL;
                    end else begin
                        // Every store goes through the buffer
                        sb_push_o = 1'b1;
                        if (!cache_hit_i) begin
                            mmu_miss_o = 1'b1;
                            latch_tag  = 1'b1;
                            state_d    = tl_types_pkg::MISS_IN_FLIGHT;
                        end
                    end
                end else begin
                    sb_flush_o = store_permission_i && sb_head_valid_i;
                end
            end
            tl_types_pkg::MISS_IN_FLIGHT: begin
                if (ex_req_i.wr) begin
                    // Only stores to the missing line may proceed
                    hazard_o  = !same_tag || sb_full_conflict_i;
                    sb_push_o = !hazard_o;
                end else if (ex_req_i.rd) begin
                    hazard_o = !cache_hit_i && (!same_tag || !sb_fwd_hit_i);
                end
                // A stalled request retries from idle once the line is back
                if (refill_rdy_i) begin
                    state_d = tl_types_pkg::TL_IDLE;
                end else if (hazard_o) begin
                    state_d = tl_types_pkg::HAZARD_DC_MISS;
                end
            end
            tl_types_pkg::HAZARD_DC_MISS: begin
                hazard_o = 1'b1;
                if (refill_rdy_i) begin
                    state_d = tl_types_pkg::TL_IDLE;
                end
            end
            tl_types_pkg::HAZARD_SB_FULL: begin
                hazard_o   = 1'b1;
                sb_flush_o = store_permission_i && sb_head_valid_i;
                if (!sb_full_conflict_i) begin
                    state_d = tl_types_pkg::TL_IDLE;
                end
            end
            default: begin
                state_d = tl_types_pkg::TL_IDLE;
            end
        endcase
    end

    // Compared only in MISS_IN_FLIGHT, which always follows a latch
    always_ff @(posedge clk_i) begin
        if (latch_tag) begin
            inflight_tag_q <= req_tag;
        end
    end

    // Set by a miss and cleared by its refill
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            miss_pending_q <= 1'b0;
        end else if (mmu_miss_o) begin
            miss_pending_q <= 1'b1;
        end else if (refill_rdy_i) begin
            miss_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        tl_out_o.sign_ext    <= ex_req_i.sign_ext;
        tl_out_o.memop_type  <= ex_req_i.memop_type;
        tl_out_o.addr        <= ex_req_i.addr;
        tl_out_o.rf_waddr    <= ex_req_i.rf_waddr;
        tl_out_o.load_data   <= sb_fwd_data_i;
        tl_out_o.flush_entry <= sb_head_i;
        if (!rst_n_i) begin
            state_q         <= tl_types_pkg::TL_IDLE;
            tl_out_o.rd     <= 1'b0;
            tl_out_o.wr     <= 1'b0;
            tl_out_o.rf_we  <= 1'b0;
            tl_out_o.sb_hit <= 1'b0;
            tl_out_o.flush  <= 1'b0;
        end else begin
            state_q         <= state_d;
            // Stalled requests leave a bubble
            tl_out_o.rd     <= ex_req_i.rd && !hazard_o;
            tl_out_o.rf_we  <= ex_req_i.rf_we && !hazard_o;
            tl_out_o.sb_hit <= ex_req_i.rd && !hazard_o && sb_fwd_hit_i;
            tl_out_o.wr     <= sb_flush_o;
            tl_out_o.flush  <= sb_flush_o;
        end
    end

    // At most one miss outstanding until its refill returns
    a_one_miss: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mmu_miss_o |-> !miss_pending_q);

endmodule

// ==== logic/tl_stage.sv ====
`timescale 1ns/10ps

module tl_stage #(
    parameter int NUM_LINES = 4,
    parameter int SB_DEPTH  = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  tl_types_pkg::ex_req_t ex_req_i,
    input  logic                  store_permission_i,
    input  tl_types_pkg::refill_t refill_i,
    output tl_types_pkg::tl_out_t tl_out_o,
    output logic                  mmu_miss_o,
    output mem_cfg_pkg::addr_t    mmu_addr_o,
    output logic                  hazard_o
);

    mem_cfg_pkg::addr_t      lookup_addr;
    logic                    cache_hit;
    logic                    sb_push;
    logic                    sb_flush;
    tl_types_pkg::sb_entry_t sb_entry;
    logic                    sb_fwd_hit;
    mem_cfg_pkg::word_t      sb_fwd_data;
    logic                    sb_full_conflict;
    logic                    sb_head_valid;
    tl_types_pkg::sb_entry_t sb_head;

    dcache_tag_array #(
        .NUM_LINES (NUM_LINES)
    ) dcache_tag_array_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .lookup_addr_i (lookup_addr),
        .refill_i      (refill_i),
        .hit_o         (cache_hit)
    );

    // Loads search the buffer with the same addr and type as a store would
    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) store_buffer_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .push_i          (sb_push),
        .push_entry_i    (sb_entry),
        .load_addr_i     (sb_entry.addr),
        .load_type_i     (sb_entry.memop_type),
        .flush_i         (sb_flush),
        .fwd_hit_o       (sb_fwd_hit),
        .fwd_data_o      (sb_fwd_data),
        .full_conflict_o (sb_full_conflict),
        .head_valid_o    (sb_head_valid),
        .head_o          (sb_head)
    );

    tl_stage_ctrl tl_stage_ctrl_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .ex_req_i           (ex_req_i),
        .store_permission_i (store_permission_i),
        .refill_rdy_i       (refill_i.rdy),
        .cache_hit_i        (cache_hit),
        .sb_fwd_hit_i       (sb_fwd_hit),
        .sb_fwd_data_i      (sb_fwd_data),
        .sb_full_conflict_i (sb_full_conflict),
        .sb_head_valid_i    (sb_head_valid),
        .sb_head_i          (sb_head),
        .lookup_addr_o      (lookup_addr),
        .sb_push_o          (sb_push),
        .sb_entry_o         (sb_entry),
        .sb_flush_o         (sb_flush),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o),
        .hazard_o           (hazard_o),
        .tl_out_o           (tl_out_o)
    );

endmodule

// ==== verif/tl_stage_tb.sv ====
`timescale 1ns/10ps

module tl_stage_tb;

    localparam int NUM_LINES  = 4;
    localparam int SB_DEPTH   = 2;
    localparam int NUM_OPS    = 400;
    localparam int CLK_PERIOD = 20;

`include "include/tl_ref_model.svh"

    logic                    clk_i;
    logic                    rst_n_i;
    tl_types_pkg::ex_req_t   ex_req_i;
    logic                    store_permission_i;
    tl_types_pkg::refill_t   refill_i;
    tl_types_pkg::tl_out_t   tl_out_o;
    logic                    mmu_miss_o;
    mem_cfg_pkg::addr_t      mmu_addr_o;
    logic                    hazard_o;

    // Reference state of the controller
    tl_types_pkg::tl_state_e state;
    mem_cfg_pkg::tag_t       inflight_tag;

    // Expectations for the output register, one cycle behind
    logic                    prev_valid;
    tl_types_pkg::ex_req_t   prev_req;
    logic                    prev_hazard;
    logic                    prev_flush;
    tl_types_pkg::sb_entry_t prev_head;
    logic                    prev_fwd;
    mem_cfg_pkg::word_t      prev_fwd_data;

    int errors;
    int checks;
    int ops_done;
    int n_miss;
    int n_fwd;
    int n_flush;
    int n_full;
    logic hold;

    tl_stage #(
        .NUM_LINES (NUM_LINES),
        .SB_DEPTH  (SB_DEPTH)
    ) tl_stage_i (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .ex_req_i           (ex_req_i),
        .store_permission_i (store_permission_i),
        .refill_i           (refill_i),
        .tl_out_o           (tl_out_o),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o),
        .hazard_o           (hazard_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    function automatic tl_types_pkg::memop_type_e random_type();
        int pick;
        pick = $urandom_range(9);
        if (pick < 6) begin
            return tl_types_pkg::WORD;
        end
        if (pick < 8) begin
            return tl_types_pkg::HALF;
        end
        return tl_types_pkg::BYTE;
    endfunction

    // Five lines over four sets, line 4 aliases line 0
    function automatic tl_types_pkg::ex_req_t random_request();
        tl_types_pkg::ex_req_t req;
        int kind;
        int line;
        req            = '0;
        kind           = $urandom_range(9);
        line           = $urandom_range(4);
        req.addr       = 32'h0000_1000 + line * 16 + $urandom_range(1) * 4;
        req.memop_type = random_type();
        req.data       = $urandom();
        req.rf_waddr   = mem_cfg_pkg::reg_addr_t'($urandom_range(31));
        req.sign_ext   = ($urandom_range(1) == 1);
        if (kind < 4) begin
            req.rd    = 1'b1;
            req.rf_we = ($urandom_range(3) != 0);
        end else if (kind < 8) begin
            req.wr = 1'b1;
        end
        return req;
    endfunction

    task automatic check_registered_output();
        logic done;
        if (!prev_valid) begin
            return;
        end
        done = (prev_req.rd || prev_req.wr) && !prev_hazard;
        check_value("tl_out_o.rd", tl_out_o.rd, prev_req.rd && !prev_hazard);
        check_value("tl_out_o.rf_we", tl_out_o.rf_we, prev_req.rf_we && !prev_hazard);
        check_value("tl_out_o.wr", tl_out_o.wr, prev_flush);
        check_value("tl_out_o.flush", tl_out_o.flush, prev_flush);
        check_value("tl_out_o.sb_hit", tl_out_o.sb_hit,
                    prev_req.rd && !prev_hazard && prev_fwd);
        if (prev_flush) begin
            check_value("tl_out_o.flush_entry", tl_out_o.flush_entry, prev_head);
        end
        if (done) begin
            check_value("tl_out_o.addr", tl_out_o.addr, prev_req.addr);
            check_value("tl_out_o.memop_type", tl_out_o.memop_type, prev_req.memop_type);
            check_value("tl_out_o.rf_waddr", tl_out_o.rf_waddr, prev_req.rf_waddr);
            check_value("tl_out_o.sign_ext", tl_out_o.sign_ext, prev_req.sign_ext);
        end
        if (done && prev_req.rd && prev_fwd) begin
            check_value("tl_out_o.load_data", tl_out_o.load_data, prev_fwd_data);
        end
    endtask

    // One cycle of the stage rules, checked against the live outputs
    task automatic model_step();
        tl_types_pkg::sb_entry_t entry;
        tl_types_pkg::tl_state_e next_state;
        int   idx;
        logic hit;
        logic fwd;
        logic conflict;
        logic same_line;
        logic exp_hazard;
        logic exp_miss;
        logic push;
        logic flush;
        entry.addr       = ex_req_i.addr;
        entry.data       = ex_req_i.data;
        entry.memop_type = ex_req_i.memop_type;
        idx        = find_entry(entry.addr, entry.memop_type);
        hit        = cache_hit(entry.addr);
        fwd        = (idx >= 0);
        conflict   = (sb_q.size() >= SB_DEPTH) && !fwd;
        same_line  = (tag_of(entry.addr) == inflight_tag);
        exp_hazard = 1'b0;
        exp_miss   = 1'b0;
        push       = 1'b0;
        flush      = 1'b0;
        next_state = state;
        case (state)
            tl_types_pkg::TL_IDLE: begin
                if (ex_req_i.rd && !hit && !fwd) begin
                    exp_miss   = 1'b1;
                    exp_hazard = 1'b1;
                    next_state = tl_types_pkg::HAZARD_DC_MISS;
                end else if (ex_req_i.wr && conflict) begin
                    exp_hazard = 1'b1;
                    next_state = tl_types_pkg::HAZARD_SB_FULL;
                end else if (ex_req_i.wr) begin
                    push = 1'b1;
                    if (!hit) begin
                        exp_miss   = 1'b1;
                        next_state = tl_types_pkg::MISS_IN_FLIGHT;
                    end
                end else if (!ex_req_i.rd) begin
                    flush = store_permission_i && (sb_q.size() > 0);
                end
            end
            tl_types_pkg::MISS_IN_FLIGHT: begin
                if (ex_req_i.wr) begin
                    exp_hazard = !same_line || conflict;
                    push       = !exp_hazard;
                end else if (ex_req_i.rd) begin
                    exp_hazard = !hit && (!same_line || !fwd);
                end
                if (refill_i.rdy) begin
                    next_state = tl_types_pkg::TL_IDLE;
                end else if (exp_hazard) begin
                    next_state = tl_types_pkg::HAZARD_DC_MISS;
                end
            end
            tl_types_pkg::HAZARD_DC_MISS: begin
                exp_hazard = 1'b1;
                if (refill_i.rdy) begin
                    next_state = tl_types_pkg::TL_IDLE;
                end
            end
            default: begin
                exp_hazard = 1'b1;
                flush      = store_permission_i && (sb_q.size() > 0);
                if (!conflict) begin
                    next_state = tl_types_pkg::TL_IDLE;
                end
            end
        endcase
        check_value("hazard_o", hazard_o, exp_hazard);
        check_value("mmu_miss_o", mmu_miss_o, exp_miss);
        if (exp_miss) begin
            check_value("mmu_addr_o", mmu_addr_o, entry.addr);
            n_miss++;
        end
        if (state == tl_types_pkg::TL_IDLE && next_state == tl_types_pkg::HAZARD_SB_FULL) begin
            n_full++;
        end
        prev_valid    = 1'b1;
        prev_req      = ex_req_i;
        prev_hazard   = exp_hazard;
        prev_flush    = flush;
        prev_fwd      = fwd;
        prev_fwd_data = fwd ? sb_q[idx].data : '0;
        prev_head     = '0;
        if (ex_req_i.rd && !exp_hazard && fwd) begin
            n_fwd++;
        end
        if (flush) begin
            prev_head = sb_q.pop_front();
            n_flush++;
        end
        if (push) begin
            write_store(entry);
        end
        if (refill_i.rdy) begin
            refill_line(refill_i.addr);
        end
        if (exp_miss && ex_req_i.wr) begin
            inflight_tag = tag_of(entry.addr);
        end
        state = next_state;
        if ((ex_req_i.rd || ex_req_i.wr) && !exp_hazard) begin
            ops_done++;
        end
    endtask

    // Memory side, answers each miss after 2 to 6 cycles
    initial begin : memory_responder
        mem_cfg_pkg::addr_t pending_addr;
        int countdown;
        refill_i     = '0;
        pending_addr = '0;
        countdown    = 0;
        forever begin
            @(negedge clk_i);
            refill_i.rdy = 1'b0;
            if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    refill_i.rdy  = 1'b1;
                    refill_i.addr = pending_addr;
                end
            end
            #2;
            if (rst_n_i && mmu_miss_o) begin
                pending_addr = mmu_addr_o;
                countdown    = 2 + $urandom_range(4);
            end
        end
    end

    initial begin : watchdog
        #(NUM_OPS * 20 * CLK_PERIOD);
        $display("Timeout: only %0d of %0d operations completed", ops_done, NUM_OPS);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'ha869));
        rst_n_i            = 1'b0;
        ex_req_i           = '0;
        store_permission_i = 1'b0;
        errors       = 0;
        checks       = 0;
        ops_done     = 0;
        n_miss       = 0;
        n_fwd        = 0;
        n_flush      = 0;
        n_full       = 0;
        hold         = 1'b0;
        prev_valid   = 1'b0;
        inflight_tag = '0;
        state        = tl_types_pkg::TL_IDLE;
        clear_model();
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        check_value("tl_out_o.rd", tl_out_o.rd, 1'b0);
        check_value("tl_out_o.wr", tl_out_o.wr, 1'b0);
        check_value("tl_out_o.rf_we", tl_out_o.rf_we, 1'b0);
        check_value("tl_out_o.sb_hit", tl_out_o.sb_hit, 1'b0);
        check_value("tl_out_o.flush", tl_out_o.flush, 1'b0);
        check_value("mmu_miss_o", mmu_miss_o, 1'b0);
        check_value("hazard_o", hazard_o, 1'b0);
        while (ops_done < NUM_OPS) begin
            @(negedge clk_i);
            check_registered_output();
            // Execute holds a stalled request
            if (!hold) begin
                ex_req_i = random_request();
            end
            // Long permission windows so the buffer fills up
            if ($urandom_range(9) == 0) begin
                store_permission_i = !store_permission_i;
            end
            #1;
            model_step();
            hold = hazard_o;
        end
        @(negedge clk_i);
        check_registered_output();
        $display("Checks %0d, errors %0d, misses %0d, forwards %0d, flushes %0d, full stalls %0d",
                 checks, errors, n_miss, n_fwd, n_flush, n_full);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/mem_cfg_pkg.sv
logic/tl_types_pkg.sv
logic/dcache_tag_array.sv
logic/store_buffer.sv
logic/tl_stage_ctrl.sv
logic/tl_stage.sv
verif/tl_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tl_stage_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
